// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rename_tb
FILELIST  = rename.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// ==== rename.f ====
rtl/rename_pkg.sv
rtl/inst_queue.sv
rtl/free_list.sv
rtl/rat.sv
rtl/rename_dispatch.sv
rtl/rename_top.sv
tb/rename_tb.sv

// ==== rtl/free_list.sv ====
module free_list (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            alloc,
    input  logic                            retire_valid,
    input  logic [rename_pkg::preg_bits-1:0] retire_preg,
    output logic [rename_pkg::preg_bits-1:0] free_preg,
    output logic                            free_empty
);
    import rename_pkg::*;

    // Registers beyond the architectural ones start out free
    localparam int fl_depth = phys_regs - arch_regs;
    localparam int ptr_bits = $clog2(fl_depth);
    localparam int cnt_bits = $clog2(fl_depth + 1);

    logic [preg_bits-1:0] fl_mem [fl_depth];
    logic [ptr_bits-1:0]  rd_ptr;
    logic [ptr_bits-1:0]  wr_ptr;
    logic [cnt_bits-1:0]  count;
    logic                 full;

    assign free_empty = (count == '0);
    assign full       = (count == cnt_bits'(fl_depth));
    assign free_preg  = fl_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Preload 32..63 in ascending order
            for (int i = 0; i < fl_depth; i++)
                fl_mem[i] <= preg_bits'(arch_regs + i);
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= cnt_bits'(fl_depth);
        end else begin
            if (retire_valid) begin
                fl_mem[wr_ptr] <= retire_preg;
                wr_ptr         <= wr_ptr + 1'b1;
            end
            if (alloc)
                rd_ptr <= rd_ptr + 1'b1;
            case ({retire_valid, alloc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst) alloc |-> !free_empty)
        else $error("free_list: allocation from an empty list");

    // Retiring more than was handed out would overwrite a free entry
    a_no_retire_full: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> !full)
        else $error("free_list: retire into a full list");

    a_no_retire_p0: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_preg != '0)
        else $error("free_list: retire of physical register 0");

endmodule

// ==== rtl/inst_queue.sv ====
module inst_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_valid,
    input  logic [rename_pkg::xlen-1:0] fetch_inst,
    input  logic [rename_pkg::xlen-1:0] fetch_pc,
    input  logic                       deq,
    output logic [rename_pkg::xlen-1:0] head_inst,
    output logic [rename_pkg::xlen-1:0] head_pc,
    output logic                       empty
);
    import rename_pkg::*;

    localparam int ptr_bits = $clog2(iq_depth);
    localparam int cnt_bits = $clog2(iq_depth + 1);

    logic [xlen-1:0]     inst_mem [iq_depth];
    logic [xlen-1:0]     pc_mem   [iq_depth];
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] wr_ptr;
    logic [cnt_bits-1:0] count;
    logic                full;

    assign empty     = (count == '0);
    assign full      = (count == cnt_bits'(iq_depth));
    assign head_inst = inst_mem[rd_ptr];
    assign head_pc   = pc_mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            inst_mem[wr_ptr] <= fetch_inst;
            pc_mem[wr_ptr]   <= fetch_pc;
        end
    end

    // Pointers and occupancy, enqueue and dequeue may coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (fetch_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq)
                rd_ptr <= rd_ptr + 1'b1;
            case ({fetch_valid, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Fetch has no back-pressure, so the source must respect capacity
    a_no_fetch_full: assert property (@(posedge clk) disable iff (rst) fetch_valid |-> !full)
        else $error("inst_queue: fetch into a full queue");

    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst) deq |-> !empty)
        else $error("inst_queue: dequeue from an empty queue");

endmodule

// ==== rtl/rat.sv ====
module rat (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [4:0]                      rs1,
    input  logic [4:0]                      rs2,
    output logic [rename_pkg::preg_bits-1:0] ps1,
    output logic [rename_pkg::preg_bits-1:0] ps2,
    input  logic                            map_we,
    input  logic [4:0]                      map_rd,
    input  logic [rename_pkg::preg_bits-1:0] map_pd
);
    import rename_pkg::*;

    logic [preg_bits-1:0] map_q [arch_regs];

    // Asynchronous reads see the table as it stood before this edge
    assign ps1 = map_q[rs1];
    assign ps2 = map_q[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, r to p r
            for (int i = 0; i < arch_regs; i++)
                map_q[i] <= preg_bits'(i);
        end else if (map_we) begin
            map_q[map_rd] <= map_pd;
        end
    end

    // x0 stays bound to p0 for good
    a_no_map_x0: assert property (@(posedge clk) disable iff (rst)
        map_we |-> map_rd != 5'd0)
        else $error("rat: remap of x0");

endmodule

// ==== rtl/rename_dispatch.sv ====
module rename_dispatch (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [rename_pkg::xlen-1:0]       head_inst,
    input  logic [rename_pkg::xlen-1:0]       head_pc,
    input  logic                             empty,
    output logic                             deq,
    input  logic [rename_pkg::preg_bits-1:0]  free_preg,
    input  logic                             free_empty,
    output logic                             alloc,
    output logic [4:0]                       rs1,
    output logic [4:0]                       rs2,
    input  logic [rename_pkg::preg_bits-1:0]  ps1,
    input  logic [rename_pkg::preg_bits-1:0]  ps2,
    output logic                             map_we,
    output logic [4:0]                       map_rd,
    output logic [rename_pkg::preg_bits-1:0]  map_pd,
    input  logic                             rob_full,
    input  logic                             rs_full_alu,
    input  logic                             rs_full_mul,
    input  logic                             rs_full_div,
    input  logic                             rs_full_br,
    output logic                             dispatch_valid,
    output rename_pkg::rs_class_e            dispatch_class,
    output logic [rename_pkg::xlen-1:0]       dispatch_inst,
    output logic [rename_pkg::xlen-1:0]       dispatch_pc,
    output logic [rename_pkg::xlen-1:0]       dispatch_imm,
    output logic [rename_pkg::order_bits-1:0] dispatch_order,
    output logic [rename_pkg::preg_bits-1:0]  dispatch_pd,
    output logic [rename_pkg::preg_bits-1:0]  dispatch_ps1,
    output logic [rename_pkg::preg_bits-1:0]  dispatch_ps2,
    output logic [4:0]                       dispatch_rd,
    output logic                             dispatch_we
);
    import rename_pkg::*;

    rv_inst_u              inst_u;
    rs_class_e             head_class;
    logic [xlen-1:0]       head_imm;
    logic                  writes_rd;
    logic                  class_full;
    logic                  accept;
    logic [order_bits-1:0] order_q;

    assign inst_u = head_inst;

    // Class rule
    always_comb begin
        head_class = cls_alu;
        if (inst_u.r.opcode == op_reg && inst_u.r.funct7 == funct7_muldiv) begin
            if (inst_u.r.funct3 inside {funct3_mul, funct3_mulh, funct3_mulhsu, funct3_mulhu})
                head_class = cls_mul;
            else if (inst_u.r.funct3 inside {funct3_div, funct3_divu, funct3_rem, funct3_remu})
                head_class = cls_div;
        end else if (inst_u.r.opcode inside {op_jal, op_jalr, op_br}) begin
            head_class = cls_br;
        end
    end

    // Immediate per format, B and J are scattered over the s and u fields
    always_comb begin
        case (inst_u.r.opcode)
            op_load, op_imm, op_jalr:
                head_imm = {{20{inst_u.i.imm_11_0[11]}}, inst_u.i.imm_11_0};
            op_store:
                head_imm = {{20{inst_u.s.imm_11_5[6]}}, inst_u.s.imm_11_5, inst_u.s.imm_4_0};
            op_br:
                head_imm = {{20{inst_u.s.imm_11_5[6]}}, inst_u.s.imm_4_0[0],
                            inst_u.s.imm_11_5[5:0], inst_u.s.imm_4_0[4:1], 1'b0};
            op_lui, op_auipc:
                head_imm = {inst_u.u.imm_31_12, 12'h000};
            op_jal:
                head_imm = {{12{inst_u.u.imm_31_12[19]}}, inst_u.u.imm_31_12[7:0],
                            inst_u.u.imm_31_12[8], inst_u.u.imm_31_12[18:9], 1'b0};
            default:
                head_imm = '0;
        endcase
    end

    assign writes_rd = (inst_u.r.opcode != op_br) && (inst_u.r.opcode != op_store) &&
                       (inst_u.r.rd != 5'd0);

    always_comb begin
        case (head_class)
            cls_mul: class_full = rs_full_mul;
            cls_div: class_full = rs_full_div;
            cls_br:  class_full = rs_full_br;
            default: class_full = rs_full_alu;
        endcase
    end

    // Free list only matters when a register is needed
    assign accept = !empty && !rob_full && !class_full && (!writes_rd || !free_empty);

    assign deq    = accept;
    assign alloc  = accept && writes_rd;
    assign rs1    = inst_u.r.rs1;
    assign rs2    = inst_u.r.rs2;
    assign map_we = alloc;
    assign map_rd = inst_u.r.rd;
    assign map_pd = free_preg;

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
            order_q        <= '0;
        end else begin
            dispatch_valid <= accept;
            if (accept)
                order_q <= order_q + 1'b1;
        end
    end

    // Payload is captured only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch_class <= head_class;
            dispatch_inst  <= head_inst;
            dispatch_pc    <= head_pc;
            dispatch_imm   <= head_imm;
            dispatch_order <= order_q;
            dispatch_pd    <= writes_rd ? free_preg : '0;
            dispatch_ps1   <= ps1;
            dispatch_ps2   <= ps2;
            dispatch_rd    <= inst_u.r.rd;
            dispatch_we    <= writes_rd;
        end
    end

endmodule

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

    // Widths and sizes
    localparam int xlen       = 32;
    localparam int arch_regs  = 32;
    localparam int phys_regs  = 64;
    localparam int preg_bits  = 6;
    localparam int iq_depth   = 8;
    localparam int order_bits = 64;

    // RV32 base opcodes
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // M extension
    localparam logic [6:0] funct7_muldiv = 7'b0000001;
    localparam logic [2:0] funct3_mul    = 3'b000;
    localparam logic [2:0] funct3_mulh   = 3'b001;
    localparam logic [2:0] funct3_mulhsu = 3'b010;
    localparam logic [2:0] funct3_mulhu  = 3'b011;
    localparam logic [2:0] funct3_div    = 3'b100;
    localparam logic [2:0] funct3_divu   = 3'b101;
    localparam logic [2:0] funct3_rem    = 3'b110;
    localparam logic [2:0] funct3_remu   = 3'b111;

    // Reservation station class
    typedef enum logic [1:0] {
        cls_alu = 2'd0,
        cls_mul = 2'd1,
        cls_div = 2'd2,
        cls_br  = 2'd3
    } rs_class_e;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } rv_inst_u;

endpackage

// ==== rtl/rename_top.sv ====
module rename_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetch_valid,
    input  logic [rename_pkg::xlen-1:0]       fetch_inst,
    input  logic [rename_pkg::xlen-1:0]       fetch_pc,
    input  logic                             retire_valid,
    input  logic [rename_pkg::preg_bits-1:0]  retire_preg,
    input  logic                             rob_full,
    input  logic                             rs_full_alu,
    input  logic                             rs_full_mul,
    input  logic                             rs_full_div,
    input  logic                             rs_full_br,
    output logic                             dispatch_valid,
    output rename_pkg::rs_class_e            dispatch_class,
    output logic [rename_pkg::xlen-1:0]       dispatch_inst,
    output logic [rename_pkg::xlen-1:0]       dispatch_pc,
    output logic [rename_pkg::xlen-1:0]       dispatch_imm,
    output logic [rename_pkg::order_bits-1:0] dispatch_order,
    output logic [rename_pkg::preg_bits-1:0]  dispatch_pd,
    output logic [rename_pkg::preg_bits-1:0]  dispatch_ps1,
    output logic [rename_pkg::preg_bits-1:0]  dispatch_ps2,
    output logic [4:0]                       dispatch_rd,
    output logic                             dispatch_we
);
    import rename_pkg::*;

    // Queue head
    logic [xlen-1:0]      head_inst;
    logic [xlen-1:0]      head_pc;
    logic                 empty;
    logic                 deq;
    // Free list head
    logic [preg_bits-1:0] free_preg;
    logic                 free_empty;
    logic                 alloc;
    // Alias table ports
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [preg_bits-1:0] ps1;
    logic [preg_bits-1:0] ps2;
    logic                 map_we;
    logic [4:0]           map_rd;
    logic [preg_bits-1:0] map_pd;

    inst_queue iq_i (
        .clk, .rst, .fetch_valid, .fetch_inst, .fetch_pc,
        .deq, .head_inst, .head_pc, .empty
    );

    free_list fl_i (
        .clk, .rst, .alloc, .retire_valid, .retire_preg,
        .free_preg, .free_empty
    );

    rat rat_i (
        .clk, .rst, .rs1, .rs2, .ps1, .ps2, .map_we, .map_rd, .map_pd
    );

    rename_dispatch rd_i (
        .clk, .rst, .head_inst, .head_pc, .empty, .deq,
        .free_preg, .free_empty, .alloc,
        .rs1, .rs2, .ps1, .ps2, .map_we, .map_rd, .map_pd,
        .rob_full, .rs_full_alu, .rs_full_mul, .rs_full_div, .rs_full_br,
        .dispatch_valid, .dispatch_class, .dispatch_inst, .dispatch_pc, .dispatch_imm,
        .dispatch_order, .dispatch_pd, .dispatch_ps1, .dispatch_ps2,
        .dispatch_rd, .dispatch_we
    );

endmodule

// ==== tb/rename_tb.sv ====
module rename_tb;
    import rename_pkg::*;

    localparam int n_insts     = 400;
    localparam int stall_bound = 20;
    localparam int clk_period  = 4;

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid;
    logic [xlen-1:0]       fetch_inst;
    logic [xlen-1:0]       fetch_pc;
    logic                  retire_valid;
    logic [preg_bits-1:0]  retire_preg;
    logic                  rob_full;
    logic                  rs_full_alu;
    logic                  rs_full_mul;
    logic                  rs_full_div;
    logic                  rs_full_br;
    logic                  dispatch_valid;
    rs_class_e             dispatch_class;
    logic [xlen-1:0]       dispatch_inst;
    logic [xlen-1:0]       dispatch_pc;
    logic [xlen-1:0]       dispatch_imm;
    logic [order_bits-1:0] dispatch_order;
    logic [preg_bits-1:0]  dispatch_pd;
    logic [preg_bits-1:0]  dispatch_ps1;
    logic [preg_bits-1:0]  dispatch_ps2;
    logic [4:0]            dispatch_rd;
    logic                  dispatch_we;

    // Reference model state
    logic [31:0]           lfsr_state;
    logic [xlen-1:0]       mq_inst [$];
    logic [xlen-1:0]       mq_pc [$];
    logic [preg_bits-1:0]  mfl [$];
    logic [preg_bits-1:0]  pool [$];
    logic [preg_bits-1:0]  mrat [arch_regs];
    logic [order_bits-1:0] morder;
    int                    fetched;
    int                    dispatched;

    rename_top dut_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        int          k;
        val = '0;
        for (k = 0; k < n; k++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return val;
    endfunction

    function automatic logic [xlen-1:0] random_inst();
        logic [xlen-1:0] word;
        logic [3:0]      pick;
        word = take_bits(32);
        pick = 4'(take_bits(4));
        case (pick)
            4'd0:  word[6:0] = op_lui;
            4'd1:  word[6:0] = op_auipc;
            4'd2:  word[6:0] = op_jal;
            4'd3:  word[6:0] = op_jalr;
            4'd4:  word[6:0] = op_br;
            4'd5:  word[6:0] = op_load;
            4'd6:  word[6:0] = op_store;
            4'd7:  word[6:0] = op_imm;
            4'd8:  word[6:0] = op_reg;
            4'd9, 4'd10, 4'd11, 4'd12: begin
                word[6:0]   = op_reg;
                word[31:25] = funct7_muldiv;
            end
            default: ;
        endcase
        // More rd zero than chance alone would give
        if (take_bits(3) == 0)
            word[11:7] = 5'd0;
        return word;
    endfunction

    function automatic rs_class_e expect_class(input logic [xlen-1:0] w);
        if (w[6:0] == op_reg && w[31:25] == funct7_muldiv) begin
            if (w[14:12] inside {funct3_mul, funct3_mulh, funct3_mulhsu, funct3_mulhu})
                return cls_mul;
            return cls_div;
        end
        if (w[6:0] inside {op_jal, op_jalr, op_br})
            return cls_br;
        return cls_alu;
    endfunction

    function automatic logic [xlen-1:0] expect_imm(input logic [xlen-1:0] w);
        case (w[6:0])
            op_load, op_imm, op_jalr: return {{20{w[31]}}, w[31:20]};
            op_store:                 return {{20{w[31]}}, w[31:25], w[11:7]};
            op_br:    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            op_lui, op_auipc:         return {w[31:12], 12'h000};
            op_jal:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:                  return '0;
        endcase
    endfunction

    function automatic logic writes_dest(input logic [xlen-1:0] w);
        return (w[6:0] != op_br) && (w[6:0] != op_store) && (w[11:7] != 5'd0);
    endfunction

    function automatic logic class_busy(input rs_class_e cls);
        case (cls)
            cls_mul: return rs_full_mul;
            cls_div: return rs_full_div;
            cls_br:  return rs_full_br;
            default: return rs_full_alu;
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
            else stop_with_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h",
                                             name, got, exp));
    endtask

    // Watchdog
    initial begin
        #(clk_period * (n_insts * stall_bound + 20));
        stop_with_failure("timeout: not all instructions were dispatched in time");
    end

    initial begin
        logic [xlen-1:0]      head;
        rs_class_e            cls;
        logic                 wr;
        logic                 exp_accept;
        logic [preg_bits-1:0] exp_pd;
        int                   idx;

        clk          = 1'b0;
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        fetch_inst   = '0;
        fetch_pc     = '0;
        retire_valid = 1'b0;
        retire_preg  = '0;
        rob_full     = 1'b0;
        rs_full_alu  = 1'b0;
        rs_full_mul  = 1'b0;
        rs_full_div  = 1'b0;
        rs_full_br   = 1'b0;
        lfsr_state   = 32'd78353;
        morder       = '0;
        fetched      = 0;
        dispatched   = 0;
        head         = '0;
        cls          = cls_alu;
        wr           = 1'b0;
        for (idx = 0; idx < arch_regs; idx++)
            mrat[idx] = preg_bits'(idx);
        for (idx = 0; idx < phys_regs - arch_regs; idx++)
            mfl.push_back(preg_bits'(arch_regs + idx));

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        compare("dispatch_valid", 64'(dispatch_valid), 64'(0));

        while (dispatched < n_insts) begin
            // Fetch only while the queue has room
            fetch_valid = (fetched < n_insts) && (mq_inst.size() < iq_depth) &&
                          (take_bits(2) != 0);
            if (fetch_valid) begin
                fetch_inst = random_inst();
                fetch_pc   = take_bits(30) << 2;
            end
            retire_valid = (pool.size() > 0) && (take_bits(2) == 0);
            if (retire_valid) begin
                idx = int'(take_bits(6)) % pool.size();
                retire_preg = pool[idx];
                pool.delete(idx);
            end
            rob_full    = (take_bits(3) == 0);
            rs_full_alu = (take_bits(3) == 0);
            rs_full_mul = (take_bits(3) == 0);
            rs_full_div = (take_bits(3) == 0);
            rs_full_br  = (take_bits(3) == 0);

            // Predicted accept for the coming edge
            exp_accept = 1'b0;
            if (mq_inst.size() > 0) begin
                head = mq_inst[0];
                cls  = expect_class(head);
                wr   = writes_dest(head);
                exp_accept = !rob_full && !class_busy(cls) && (!wr || mfl.size() > 0);
            end

            @(posedge clk);
            #1;
            compare("dispatch_valid", 64'(dispatch_valid), 64'(exp_accept));
            if (exp_accept) begin
                exp_pd = wr ? mfl[0] : '0;
                compare("dispatch_class", 64'(dispatch_class), 64'(cls));
                compare("dispatch_inst", 64'(dispatch_inst), 64'(head));
                compare("dispatch_pc", 64'(dispatch_pc), 64'(mq_pc[0]));
                compare("dispatch_imm", 64'(dispatch_imm), 64'(expect_imm(head)));
                compare("dispatch_order", dispatch_order, morder);
                compare("dispatch_pd", 64'(dispatch_pd), 64'(exp_pd));
                compare("dispatch_ps1", 64'(dispatch_ps1), 64'(mrat[head[19:15]]));
                compare("dispatch_ps2", 64'(dispatch_ps2), 64'(mrat[head[24:20]]));
                compare("dispatch_rd", 64'(dispatch_rd), 64'(head[11:7]));
                compare("dispatch_we", 64'(dispatch_we), 64'(wr));
                void'(mq_inst.pop_front());
                void'(mq_pc.pop_front());
                // Old mapping becomes retireable once overwritten
                if (wr) begin
                    pool.push_back(mrat[head[11:7]]);
                    mrat[head[11:7]] = mfl.pop_front();
                end
                morder++;
                dispatched++;
            end
            if (fetch_valid) begin
                mq_inst.push_back(fetch_inst);
                mq_pc.push_back(fetch_pc);
                fetched++;
            end
            if (retire_valid)
                mfl.push_back(retire_preg);
        end

        // Drained queue must stay silent with every stall released
        fetch_valid  = 1'b0;
        retire_valid = 1'b0;
        rob_full     = 1'b0;
        rs_full_alu  = 1'b0;
        rs_full_mul  = 1'b0;
        rs_full_div  = 1'b0;
        rs_full_br   = 1'b0;
        repeat (iq_depth) begin
            @(posedge clk);
            #1;
            compare("dispatch_valid", 64'(dispatch_valid), 64'(0));
        end

        $display("** PASS **");
        $finish;
    end

endmodule
